//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = fsb_adapter_tb
FILELIST = fsb_adapter.f
PASS_MSG = Finished with no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- common/axis_stream_pkg.sv
// ------------------------------
// wide stream side constants
// defaults for the shell facing axi-stream beat, built from whole fsb words
// ------------------------------

package axis_stream_pkg;

  // ------------------------------
  // beat geometry
  // ------------------------------

  // a wide beat always holds a whole number of fsb words, so the width
  // is derived from the word size rather than set on its own
  localparam int FSB_RATIO = 4;  // fsb words per wide beat

  localparam int WIDE_W      = fsb_pkg::FSB_W * FSB_RATIO;  // 320 bit tdata
  localparam int WIDE_KEEP_W = WIDE_W / 8;                  // one keep bit per byte

endpackage

//--- common/fsb_pkg.sv
// ------------------------------
// fsb word side constants
// one fsb word is the unit moved over the adpt_master and adpt_slave ports
// ------------------------------

package fsb_pkg;

  // ------------------------------
  // word geometry
  // ------------------------------

  localparam int FSB_W     = 80;         // bits per fsb word
  localparam int FSB_BYTES = FSB_W / 8;  // keep group size for one slice

endpackage

//--- design/axis_downsizer.sv
// ------------------------------
// wide beat to fsb word splitter
// emits kept slices from slice 0 upward, last on the top kept slice
// ------------------------------

`timescale 1ns/100ps

module axis_downsizer #(
  parameter int RATIO = axis_stream_pkg::FSB_RATIO
) (
  input                                 clk_i
  ,input                                arst_n_i
  ,input                                s_valid_i
  ,input  [RATIO*fsb_pkg::FSB_W-1:0]    s_data_i
  ,input  [RATIO*fsb_pkg::FSB_BYTES-1:0] s_keep_i
  ,input                                s_last_i
  ,output                               s_ready_o
  ,output                               fsb_v_o
  ,output [fsb_pkg::FSB_W-1:0]          fsb_data_o
  ,output                               fsb_last_o
  ,input                                fsb_r_i
);

  import fsb_pkg::*;

  localparam int IDX_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  logic                     busy_q;
  logic [IDX_W-1:0]         idx_q, top_idx_q;
  logic [IDX_W-1:0]         top_idx;
  logic [RATIO-1:0]         kept;
  logic [RATIO*FSB_W-1:0]   beat_q;
  logic                     last_q;
  logic                     final_slice, load, word_xfer;

  // ------------------------------
  // keep reduction
  // ------------------------------

  always_comb begin
    top_idx = '0;
    for (int k = 0; k < RATIO; k++) begin
      kept[k] = |s_keep_i[k*FSB_BYTES +: FSB_BYTES];
      if (kept[k]) begin
        top_idx = IDX_W'(k);                     // kept slices are contiguous
      end
    end
  end

  // ------------------------------
  // word sequencing
  // ------------------------------

  assign final_slice = (idx_q == top_idx_q);
  assign word_xfer   = busy_q & fsb_r_i;
  assign s_ready_o   = ~busy_q | (fsb_r_i & final_slice);  // reload with no gap
  assign load        = s_valid_i & s_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (word_xfer) begin
      if (final_slice) begin
        busy_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      beat_q    <= s_data_i;
      last_q    <= s_last_i;
      top_idx_q <= top_idx;
    end
  end

  assign fsb_v_o    = busy_q;
  assign fsb_data_o = beat_q[idx_q*FSB_W +: FSB_W];
  assign fsb_last_o = last_q & final_slice;      // only on top kept slice

endmodule

//--- design/axis_reg_slice.sv
// ------------------------------
// axi-stream register slice
// main plus skid register, full rate, input ready taken from a flop
// ------------------------------

`timescale 1ns/100ps

module axis_reg_slice #(
  parameter int DATA_W = axis_stream_pkg::WIDE_W
) (
  input                     clk_i
  ,input                    arst_n_i
  ,input                    s_valid_i
  ,input  [DATA_W-1:0]      s_data_i
  ,input  [DATA_W/8-1:0]    s_keep_i
  ,input                    s_last_i
  ,output                   s_ready_o
  ,output                   m_valid_o
  ,output [DATA_W-1:0]      m_data_o
  ,output [DATA_W/8-1:0]    m_keep_o
  ,output                   m_last_o
  ,input                    m_ready_i
);

  logic                  main_valid_q, skid_valid_q, ready_q;
  logic                  main_valid_nxt, skid_valid_nxt;
  logic                  main_load, in_xfer;
  logic [DATA_W-1:0]     main_data_q, skid_data_q;
  logic [DATA_W/8-1:0]   main_keep_q, skid_keep_q;
  logic                  main_last_q, skid_last_q;

  assign in_xfer   = s_valid_i & ready_q;
  assign main_load = ~main_valid_q | m_ready_i;  // main empty or draining

  always_comb begin
    main_valid_nxt = main_valid_q;
    skid_valid_nxt = skid_valid_q;
    if (main_load) begin
      main_valid_nxt = skid_valid_q | in_xfer;
      skid_valid_nxt = 1'b0;                     // skid moves into main
    end else if (in_xfer) begin
      skid_valid_nxt = 1'b1;                     // main stalled, park beat
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;                      // low for one cycle after reset
    end else begin
      main_valid_q <= main_valid_nxt;
      skid_valid_q <= skid_valid_nxt;
      ready_q      <= ~skid_valid_nxt;           // falls only when both full
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_data_q <= skid_valid_q ? skid_data_q : s_data_i;
      main_keep_q <= skid_valid_q ? skid_keep_q : s_keep_i;
      main_last_q <= skid_valid_q ? skid_last_q : s_last_i;
    end
    if (!main_load && in_xfer) begin
      skid_data_q <= s_data_i;
      skid_keep_q <= s_keep_i;
      skid_last_q <= s_last_i;
    end
  end

  assign s_ready_o = ready_q;
  assign m_valid_o = main_valid_q;
  assign m_data_o  = main_data_q;
  assign m_keep_o  = main_keep_q;
  assign m_last_o  = main_last_q;

endmodule

//--- design/axis_upsizer.sv
// ------------------------------
// fsb word to wide beat packer
// fills slices in arrival order, closes on a full beat or on last
// ------------------------------

`timescale 1ns/100ps

module axis_upsizer #(
  parameter int RATIO = axis_stream_pkg::FSB_RATIO
) (
  input                                  clk_i
  ,input                                 arst_n_i
  ,input                                 fsb_v_i
  ,input  [fsb_pkg::FSB_W-1:0]           fsb_data_i
  ,input                                 fsb_last_i
  ,output                                fsb_r_o
  ,output                                m_valid_o
  ,output [RATIO*fsb_pkg::FSB_W-1:0]     m_data_o
  ,output logic [RATIO*fsb_pkg::FSB_BYTES-1:0] m_keep_o
  ,output                                m_last_o
  ,input                                 m_ready_i
);

  import fsb_pkg::*;

  localparam int WIDE_W = RATIO * FSB_W;
  localparam int CNT_W  = $clog2(RATIO + 1);

  logic [CNT_W-1:0]      cnt_q;                  // words held in build_q
  logic                  out_valid_q, rdy_en_q;
  logic [WIDE_W-1:0]     build_q;
  logic                  last_q;
  logic                  word_xfer, close;

  assign fsb_r_o   = rdy_en_q & ~out_valid_q;    // hold off while beat waits
  assign word_xfer = fsb_v_i & fsb_r_o;
  assign close     = word_xfer & (fsb_last_i | (cnt_q == CNT_W'(RATIO - 1)));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
      rdy_en_q    <= 1'b0;
    end else begin
      rdy_en_q <= 1'b1;
      if (out_valid_q && m_ready_i) begin
        out_valid_q <= 1'b0;
        cnt_q       <= '0;
      end
      if (word_xfer) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (close) begin
        out_valid_q <= 1'b1;
      end
    end
  end

  // ------------------------------
  // build register
  // ------------------------------

  // the first word of a beat wipes the rest so unfilled slices read as zero
  always_ff @(posedge clk_i) begin
    if (word_xfer) begin
      if (cnt_q == '0) begin
        build_q <= WIDE_W'(fsb_data_i);
      end else begin
        build_q[cnt_q*FSB_W +: FSB_W] <= fsb_data_i;
      end
    end
    if (close) begin
      last_q <= fsb_last_i;
    end
  end

  always_comb begin
    for (int k = 0; k < RATIO; k++) begin
      m_keep_o[k*FSB_BYTES +: FSB_BYTES] = {FSB_BYTES{cnt_q > CNT_W'(k)}};
    end
  end

  assign m_valid_o = out_valid_q;
  assign m_data_o  = build_q;
  assign m_last_o  = last_q;                     // last flag of closing word

endmodule

//--- design/s_axis_fsb_adapter.sv
// ------------------------------
// axi-stream <-> fsb adapter
// tx: wide beat through a register slice, then split into fsb words
// rx: fsb words packed back into wide beats
// ------------------------------

`timescale 1ns/100ps

module s_axis_fsb_adapter #(
  parameter int RATIO = axis_stream_pkg::FSB_RATIO
) (
  input                                      clk_i
  ,input                                     arst_n_i
  ,input                                     s_axis_tvalid_i
  ,input  [axis_stream_pkg::WIDE_W-1:0]      s_axis_tdata_i
  ,input  [axis_stream_pkg::WIDE_KEEP_W-1:0] s_axis_tkeep_i
  ,input                                     s_axis_tlast_i
  ,output                                    s_axis_tready_o
  ,output                                    adpt_master_v_o
  ,output [fsb_pkg::FSB_W-1:0]               adpt_master_data_o
  ,output                                    adpt_master_last_o
  ,input                                     adpt_master_r_i
  ,input                                     adpt_slave_v_i
  ,input  [fsb_pkg::FSB_W-1:0]               adpt_slave_data_i
  ,input                                     adpt_slave_last_i
  ,output                                    adpt_slave_r_o
  ,output                                    m_axis_tvalid_o
  ,output [axis_stream_pkg::WIDE_W-1:0]      m_axis_tdata_o
  ,output [axis_stream_pkg::WIDE_KEEP_W-1:0] m_axis_tkeep_o
  ,output                                    m_axis_tlast_o
  ,input                                     m_axis_tready_i
);

  import fsb_pkg::*;

  localparam int DATA_W = RATIO * FSB_W;

  // slice to downsizer
  logic                 sl_valid, sl_last, sl_ready;
  logic [DATA_W-1:0]    sl_data;
  logic [DATA_W/8-1:0]  sl_keep;

  // ------------------------------
  // transmit path
  // ------------------------------

  axis_reg_slice #(
    .DATA_W(DATA_W)
  ) tx_slice (
    .clk_i    (clk_i          )
    ,.arst_n_i (arst_n_i       )
    ,.s_valid_i(s_axis_tvalid_i)
    ,.s_data_i (s_axis_tdata_i )
    ,.s_keep_i (s_axis_tkeep_i )
    ,.s_last_i (s_axis_tlast_i )
    ,.s_ready_o(s_axis_tready_o)
    ,.m_valid_o(sl_valid       )
    ,.m_data_o (sl_data        )
    ,.m_keep_o (sl_keep        )
    ,.m_last_o (sl_last        )
    ,.m_ready_i(sl_ready       )
  );

  axis_downsizer #(
    .RATIO(RATIO)
  ) tx_down (
    .clk_i      (clk_i             )
    ,.arst_n_i  (arst_n_i          )
    ,.s_valid_i (sl_valid          )
    ,.s_data_i  (sl_data           )
    ,.s_keep_i  (sl_keep           )
    ,.s_last_i  (sl_last           )
    ,.s_ready_o (sl_ready          )
    ,.fsb_v_o   (adpt_master_v_o   )
    ,.fsb_data_o(adpt_master_data_o)
    ,.fsb_last_o(adpt_master_last_o)
    ,.fsb_r_i   (adpt_master_r_i   )
  );

  // ------------------------------
  // receive path
  // ------------------------------

  axis_upsizer #(
    .RATIO(RATIO)
  ) rx_up (
    .clk_i      (clk_i            )
    ,.arst_n_i  (arst_n_i         )
    ,.fsb_v_i   (adpt_slave_v_i   )
    ,.fsb_data_i(adpt_slave_data_i)
    ,.fsb_last_i(adpt_slave_last_i)
    ,.fsb_r_o   (adpt_slave_r_o   )
    ,.m_valid_o (m_axis_tvalid_o  )
    ,.m_data_o  (m_axis_tdata_o   )
    ,.m_keep_o  (m_axis_tkeep_o   )
    ,.m_last_o  (m_axis_tlast_o   )
    ,.m_ready_i (m_axis_tready_i  )
  );

endmodule

//--- dv/fsb_adapter_tb.sv
// ------------------------------
// fsb adapter testbench
// replays vector records on both paths under random output ready
// and checks every fsb word and wide beat that leaves the DUT
// ------------------------------

`timescale 1ns/100ps

module fsb_adapter_tb;

  import fsb_pkg::*;
  import axis_stream_pkg::*;

  localparam int REC_W    = 8 + WIDE_KEEP_W + WIDE_W;  // kind, last, keep, data
  localparam int CMP_W    = 1 + WIDE_KEEP_W + WIDE_W;
  localparam int LAST_BIT = WIDE_W + WIDE_KEEP_W;
  localparam int MAX_REC  = 64;
  localparam int RX_PASSES = 2;                  // later passes start on a full build register

  logic                   clk, arst_n, started;
  logic                   s_valid, s_last, s_ready;
  logic [WIDE_W-1:0]      s_data;
  logic [WIDE_KEEP_W-1:0] s_keep;
  logic                   fsb_out_v, fsb_out_last, fsb_out_r;
  logic [FSB_W-1:0]       fsb_out_data;
  logic                   fsb_in_v, fsb_in_last, fsb_in_r;
  logic [FSB_W-1:0]       fsb_in_data;
  logic                   m_valid, m_last, m_ready;
  logic [WIDE_W-1:0]      m_data;
  logic [WIDE_KEEP_W-1:0] m_keep;
  logic [31:0]            rnd;

  logic [REC_W-1:0] vec_mem [0:MAX_REC-1];
  int               wide_in[$], fsb_in[$], fsb_exp[$], wide_exp[$];
  int               n_records = 0;
  int               n_fsb_exp = 0;
  int               n_wide_exp = 0;
  int               fsb_seen = 0;
  int               wide_seen = 0;

  s_axis_fsb_adapter uut (
    .clk_i             (clk         )
    ,.arst_n_i          (arst_n      )
    ,.s_axis_tvalid_i   (s_valid     )
    ,.s_axis_tdata_i    (s_data      )
    ,.s_axis_tkeep_i    (s_keep      )
    ,.s_axis_tlast_i    (s_last      )
    ,.s_axis_tready_o   (s_ready     )
    ,.adpt_master_v_o   (fsb_out_v   )
    ,.adpt_master_data_o(fsb_out_data)
    ,.adpt_master_last_o(fsb_out_last)
    ,.adpt_master_r_i   (fsb_out_r   )
    ,.adpt_slave_v_i    (fsb_in_v    )
    ,.adpt_slave_data_i (fsb_in_data )
    ,.adpt_slave_last_i (fsb_in_last )
    ,.adpt_slave_r_o    (fsb_in_r    )
    ,.m_axis_tvalid_o   (m_valid     )
    ,.m_axis_tdata_o    (m_data      )
    ,.m_axis_tkeep_o    (m_keep      )
    ,.m_axis_tlast_o    (m_last      )
    ,.m_axis_tready_i   (m_ready     )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                      // 20 ns period
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped on failure");
  endtask

  task automatic compare_values(input string name, input logic [CMP_W-1:0] expected,
                                input logic [CMP_W-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  task automatic send_wide_beats();
    logic xfer;
    foreach (wide_in[j]) begin
      s_valid = 1'b1;
      s_data  = vec_mem[wide_in[j]][0 +: WIDE_W];
      s_keep  = vec_mem[wide_in[j]][WIDE_W +: WIDE_KEEP_W];
      s_last  = vec_mem[wide_in[j]][LAST_BIT];
      do begin
        @(negedge clk);
        xfer = s_ready;                          // stable until next edge
        @(posedge clk);
      end while (!xfer);
      #2;
    end
    s_valid = 1'b0;
  endtask

  task automatic send_fsb_words();
    logic xfer;
    repeat (RX_PASSES) begin
      foreach (fsb_in[j]) begin
        fsb_in_v    = 1'b1;
        fsb_in_data = vec_mem[fsb_in[j]][0 +: FSB_W];
        fsb_in_last = vec_mem[fsb_in[j]][LAST_BIT];
        do begin
          @(negedge clk);
          xfer = fsb_in_r;
          @(posedge clk);
        end while (!xfer);
        #2;
      end
    end
    fsb_in_v = 1'b0;
  endtask

  task automatic toggle_readies();
    forever begin
      rnd       = next_random(rnd);
      fsb_out_r = |rnd[17:16];                   // high about 3 of 4 cycles
      m_ready   = |rnd[25:24];
      @(posedge clk);
      #2;
    end
  endtask

  // ------------------------------
  // output checkers
  // ------------------------------

  always @(negedge clk) begin
    if (started && fsb_out_v && fsb_out_r) begin
      if (fsb_seen >= n_fsb_exp) begin
        report_failure("an extra fsb word left adpt_master after all expected words");
      end else begin
        compare_values($sformatf("tx word %0d", fsb_seen),
                       CMP_W'({vec_mem[fsb_exp[fsb_seen]][LAST_BIT],
                               vec_mem[fsb_exp[fsb_seen]][0 +: FSB_W]}),
                       CMP_W'({fsb_out_last, fsb_out_data}));
        fsb_seen++;
      end
    end
  end

  always @(negedge clk) begin
    if (started && m_valid && m_ready) begin
      if (wide_seen >= n_wide_exp) begin
        report_failure("an extra wide beat left m_axis after all expected beats");
      end else begin
        compare_values($sformatf("rx beat %0d", wide_seen),
                       CMP_W'({vec_mem[wide_exp[wide_seen % wide_exp.size()]][LAST_BIT],
                               vec_mem[wide_exp[wide_seen % wide_exp.size()]][0 +: LAST_BIT]}),
                       CMP_W'({m_last, m_keep, m_data}));
        wide_seen++;
      end
    end
  end

  initial begin
    wait (n_records > 0);
    repeat (n_records * 40) @(posedge clk);
    $display("timeout: the DUT stopped moving data before all records were seen");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin
    arst_n      = 1'b0;
    started     = 1'b0;
    s_valid     = 1'b0;
    s_data      = '0;
    s_keep      = '0;
    s_last      = 1'b0;
    fsb_out_r   = 1'b0;
    fsb_in_v    = 1'b0;
    fsb_in_data = '0;
    fsb_in_last = 1'b0;
    m_ready     = 1'b0;
    rnd         = 32'h8cfcb336;
    $readmemh("dv/fsb_adapter_vectors.mem", vec_mem);
    for (int i = 0; i < MAX_REC; i++) begin
      case (vec_mem[i][REC_W-1 -: 4])
        4'd1: wide_in.push_back(i);
        4'd2: fsb_in.push_back(i);
        4'd3: fsb_exp.push_back(i);
        4'd4: wide_exp.push_back(i);
        default: ;                               // unused entry
      endcase
    end
    n_fsb_exp  = fsb_exp.size();
    n_wide_exp = RX_PASSES * wide_exp.size();
    n_records  = wide_in.size() + fsb_in.size() + fsb_exp.size() + wide_exp.size();
    if (n_records == 0) begin
      report_failure("no records were loaded from the vector file");
    end
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    #1;
    compare_values("quiet after reset", '0,
                   CMP_W'({s_ready, fsb_out_v, fsb_in_r, m_valid}));
    @(posedge clk);
    #2;
    started = 1'b1;
    fork
      send_wide_beats();
      send_fsb_words();
      toggle_readies();
    join_none
    wait (fsb_seen == n_fsb_exp && wide_seen == n_wide_exp);
    repeat (10) @(posedge clk);                  // catch any late extra output
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- dv/fsb_adapter_vectors.mem
// kind_last_keep_data with kind 1 wide in, 2 fsb in, 3 fsb expected, 4 wide expected
// data runs from slice 3 down to slice 0 and an fsb word sits in slice 0
1_1_ffffffffff_a0030123456789abcdef_a0020123456789abcdef_a0010123456789abcdef_a0000123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_a0000123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_a0010123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_a0020123456789abcdef
3_1_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_a0030123456789abcdef
1_1_00000fffff_dead0123456789abcdef_dead0123456789abcdef_c0010123456789abcdef_c0000123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_c0000123456789abcdef
3_1_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_c0010123456789abcdef
1_0_ffffffffff_d0030123456789abcdef_d0020123456789abcdef_d0010123456789abcdef_d0000123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_d0000123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_d0010123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_d0020123456789abcdef
3_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_d0030123456789abcdef
2_1_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b1000123456789abcdef
4_1_00000003ff_00000000000000000000_00000000000000000000_00000000000000000000_b1000123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b2000123456789abcdef
2_1_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b2010123456789abcdef
4_1_00000fffff_00000000000000000000_00000000000000000000_b2010123456789abcdef_b2000123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b3000123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b3010123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b3020123456789abcdef
2_1_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b3030123456789abcdef
4_1_ffffffffff_b3030123456789abcdef_b3020123456789abcdef_b3010123456789abcdef_b3000123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b4000123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b4010123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b4020123456789abcdef
2_0_0000000000_00000000000000000000_00000000000000000000_00000000000000000000_b4030123456789abcdef
4_0_ffffffffff_b4030123456789abcdef_b4020123456789abcdef_b4010123456789abcdef_b4000123456789abcdef

//--- fsb_adapter.f
common/fsb_pkg.sv
common/axis_stream_pkg.sv
design/axis_reg_slice.sv
design/axis_downsizer.sv
design/axis_upsizer.sv
design/s_axis_fsb_adapter.sv
dv/fsb_adapter_tb.sv
